/* verilog/merger_pkg.sv */
//************************************************************
// record and control types shared by the merge node
//************************************************************

package merger_pkg;

   typedef logic [15:0] key_t;     // zero marks the terminator.
   typedef logic [15:0] value_t;   // payload, not compared.

   // the key sits in the upper half so a record compares by key first.
   typedef struct packed {
      key_t   key;
      value_t value;
   } record_t;

   typedef enum logic [1:0] {
      S_PRIME,   // first beat of a run goes to the carry.
      S_MERGE,   // one merge per cycle.
      S_FLUSH,   // carry goes out.
      S_END      // terminator goes out.
   } ctrl_state_t;

   // lane 0 holds the smallest record, so one lane decides.
   function automatic logic is_terminator(record_t first);
      return first.key == key_t'(0);
   endfunction

endpackage

/* verilog/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
   parameter int WIDTH = 32,
   parameter int DEPTH = 8
) (
   input  logic             i_clk,
   input  logic             i_rst,
   input  logic [WIDTH-1:0] i_data,
   input  logic             i_enq,
   input  logic             i_deq,
   output logic [WIDTH-1:0] o_data,
   output logic             o_empty,
   output logic             o_full,
   output logic             o_almost_full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   typedef logic [PTR_W-1:0] ptr_t;
   typedef logic [CNT_W-1:0] count_t;

   logic [WIDTH-1:0] mem [DEPTH];
   ptr_t             wr_ptr;
   ptr_t             rd_ptr;
   count_t           count;
   logic             do_enq;
   logic             do_deq;

   // wraps for any depth, not only powers of two.
   function automatic ptr_t next_ptr(ptr_t p);
      return (p == ptr_t'(DEPTH - 1)) ? ptr_t'(0) : ptr_t'(p + 1'b1);
   endfunction

   assign do_enq = i_enq & ~o_full;    // enqueue into a full buffer is dropped.
   assign do_deq = i_deq & ~o_empty;   // dequeue from an empty buffer is dropped.

   //**********************************************************
   // pointers and occupancy
   //**********************************************************
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_enq) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_deq) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({do_enq, do_deq})
            2'b10:   count <= count_t'(count + 1'b1);
            2'b01:   count <= count_t'(count - 1'b1);
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (do_enq) begin
         mem[wr_ptr] <= i_data;
      end
   end

   assign o_data        = mem[rd_ptr];   // first word falls through.
   assign o_empty       = (count == count_t'(0));
   assign o_full        = (count == count_t'(DEPTH));
   assign o_almost_full = (int'(count) >= DEPTH - 2);   // two or fewer free.

endmodule

/* verilog/bitonic_merge_network.sv */
`timescale 1ns/1ps

module bitonic_merge_network import merger_pkg::*; #(
   parameter int LANES = 4
) (
   input  record_t [LANES-1:0] i_lo_beat,
   input  record_t [LANES-1:0] i_hi_beat,
   output record_t [LANES-1:0] o_low_beat,
   output record_t [LANES-1:0] o_high_beat
);

   localparam int N      = 2 * LANES;
   localparam int LEVELS = $clog2(N);

   // stage[0] is the bitonic input, stage[LEVELS] is fully sorted.
   record_t stage [LEVELS+1][N];

   // true when the pair is already in ascending key order.
   function automatic logic in_order(record_t lo, record_t hi);
      return lo.key <= hi.key;
   endfunction

   genvar i;
   genvar k;

   generate
      //**********************************************************
      // bitonic sequence: lo ascending, hi reversed
      //**********************************************************
      for (i = 0; i < LANES; i++) begin : g_load
         assign stage[0][i]         = i_lo_beat[i];
         assign stage[0][N - 1 - i] = i_hi_beat[i];   // largest record of hi lands in the middle.
      end

      //**********************************************************
      // half cleaner levels
      //**********************************************************
      // each level compares records D apart inside blocks of 2*D,
      // and D halves from level to level.
      for (k = 0; k < LEVELS; k++) begin : g_level
         localparam int D = N >> (k + 1);

         for (i = 0; i < N / 2; i++) begin : g_cmp
            localparam int LO = (i / D) * 2 * D + (i % D);
            localparam int HI = LO + D;

            logic keep;

            assign keep = in_order(stage[k][LO], stage[k][HI]);

            assign stage[k+1][LO] = keep ? stage[k][LO] : stage[k][HI];
            assign stage[k+1][HI] = keep ? stage[k][HI] : stage[k][LO];
         end
      end

      //**********************************************************
      // split into two ascending beats
      //**********************************************************
      for (i = 0; i < LANES; i++) begin : g_out
         assign o_low_beat[i]  = stage[LEVELS][i];
         assign o_high_beat[i] = stage[LEVELS][LANES + i];
      end
   endgenerate

endmodule

/* verilog/merge_control.sv */
`timescale 1ns/1ps

module merge_control import merger_pkg::*; #(
   parameter int LANES = 4
) (
   input  logic                i_clk,
   input  logic                i_rst,
   input  record_t [LANES-1:0] i_a_head,
   input  logic                i_a_empty,
   input  record_t [LANES-1:0] i_b_head,
   input  logic                i_b_empty,
   input  logic                i_out_almost_full,
   input  record_t [LANES-1:0] i_low_beat,
   input  record_t [LANES-1:0] i_high_beat,
   output logic                o_a_deq,
   output logic                o_b_deq,
   output record_t [LANES-1:0] o_merge_beat,
   output record_t [LANES-1:0] o_carry_beat,
   output logic                o_emit,
   output record_t [LANES-1:0] o_emit_beat
);

   typedef record_t [LANES-1:0] beat_t;

   ctrl_state_t state;
   beat_t       carry;         // upper half of the last merge.
   logic        a_term;
   logic        b_term;
   logic        both_term;
   logic        heads_ok;
   logic        take_a;
   logic        go;
   logic        consume;

   //**********************************************************
   // input selection
   //**********************************************************
   assign a_term    = is_terminator(i_a_head[0]);
   assign b_term    = is_terminator(i_b_head[0]);
   assign both_term = a_term & b_term;
   assign heads_ok  = ~i_a_empty & ~i_b_empty;

   // a wins ties, and an ended stream never wins against a live one.
   assign take_a = ~a_term & (b_term | (i_a_head[0].key <= i_b_head[0].key));

   // priming and merging compare both heads, so both must be present.
   always_comb begin
      case (state)
         S_PRIME, S_MERGE: go = heads_ok & ~i_out_almost_full;
         default:          go = ~i_out_almost_full;
      endcase
   end

   assign consume = go & ((state == S_PRIME) | (state == S_MERGE));

   // both terminators leave together at the end of a run.
   assign o_a_deq = consume & (take_a | both_term);
   assign o_b_deq = consume & ~take_a;

   assign o_merge_beat = take_a ? i_a_head : i_b_head;
   assign o_carry_beat = carry;

   //**********************************************************
   // state machine and carry
   //**********************************************************
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state  <= S_PRIME;
         carry  <= '0;
         o_emit <= 1'b0;
      end else begin
         o_emit <= 1'b0;
         if (go) begin
            case (state)
               S_PRIME: begin
                  if (both_term) begin
                     state <= S_END;   // both streams empty, only a terminator.
                  end else begin
                     carry <= o_merge_beat;
                     state <= S_MERGE;
                  end
               end
               S_MERGE: begin
                  if (both_term) begin
                     state <= S_FLUSH;
                  end else begin
                     carry  <= i_high_beat;
                     o_emit <= 1'b1;
                  end
               end
               S_FLUSH: begin
                  o_emit <= 1'b1;
                  state  <= S_END;
               end
               S_END: begin
                  o_emit <= 1'b1;
                  carry  <= '0;
                  state  <= S_PRIME;
               end
               default: begin
                  state <= S_PRIME;
               end
            endcase
         end
      end
   end

   //**********************************************************
   // output beat register
   //**********************************************************
   always_ff @(posedge i_clk) begin
      if (go) begin
         case (state)
            S_MERGE: o_emit_beat <= i_low_beat;   // lower half is final.
            S_FLUSH: o_emit_beat <= carry;
            S_END:   o_emit_beat <= '0;           // terminator beat.
            default: o_emit_beat <= o_emit_beat;
         endcase
      end
   end

endmodule

/* verilog/merger.sv */
`timescale 1ns/1ps

module merger import merger_pkg::*; #(
   parameter int LANES     = 4,
   parameter int IN_DEPTH  = 8,
   parameter int OUT_DEPTH = 8
) (
   input  logic                i_clk,
   input  logic                i_rst,
   input  record_t [LANES-1:0] i_a_data,
   input  logic                i_a_empty,
   input  record_t [LANES-1:0] i_b_data,
   input  logic                i_b_empty,
   input  logic                i_out_ready,
   output logic                o_a_read,
   output logic                o_b_read,
   output logic                o_out_write,
   output record_t [LANES-1:0] o_out_data
);

   localparam int BEAT_W = LANES * $bits(record_t);

   typedef record_t [LANES-1:0] beat_t;

   beat_t a_head;
   beat_t b_head;
   beat_t merge_beat;
   beat_t carry_beat;
   beat_t low_beat;
   beat_t high_beat;
   beat_t emit_beat;
   logic  a_empty;
   logic  a_full;
   logic  b_empty;
   logic  b_full;
   logic  a_deq;
   logic  b_deq;
   logic  emit;
   logic  out_empty;
   logic  out_almost_full;
   logic  ready_q;   // downstream ready, one cycle late.

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= i_out_ready;
      end
   end

   assign o_a_read    = ~i_a_empty & ~a_full;
   assign o_b_read    = ~i_b_empty & ~b_full;
   assign o_out_write = ready_q & ~out_empty;

   //**********************************************************
   // input buffers
   //**********************************************************
   sync_fifo #(.WIDTH(BEAT_W), .DEPTH(IN_DEPTH)) fifo_a (
      .i_clk(i_clk), .i_rst(i_rst), .i_data(i_a_data), .i_enq(o_a_read), .i_deq(a_deq),
      .o_data(a_head), .o_empty(a_empty), .o_full(a_full), .o_almost_full());

   sync_fifo #(.WIDTH(BEAT_W), .DEPTH(IN_DEPTH)) fifo_b (
      .i_clk(i_clk), .i_rst(i_rst), .i_data(i_b_data), .i_enq(o_b_read), .i_deq(b_deq),
      .o_data(b_head), .o_empty(b_empty), .o_full(b_full), .o_almost_full());

   //**********************************************************
   // merge datapath
   //**********************************************************
   merge_control #(.LANES(LANES)) merge_control_i (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_a_head(a_head), .i_a_empty(a_empty), .i_b_head(b_head), .i_b_empty(b_empty),
      .i_out_almost_full(out_almost_full), .i_low_beat(low_beat), .i_high_beat(high_beat),
      .o_a_deq(a_deq), .o_b_deq(b_deq), .o_merge_beat(merge_beat), .o_carry_beat(carry_beat),
      .o_emit(emit), .o_emit_beat(emit_beat));

   bitonic_merge_network #(.LANES(LANES)) bitonic_merge_network_i (
      .i_lo_beat(carry_beat), .i_hi_beat(merge_beat),
      .o_low_beat(low_beat), .o_high_beat(high_beat));

   sync_fifo #(.WIDTH(BEAT_W), .DEPTH(OUT_DEPTH)) fifo_out (
      .i_clk(i_clk), .i_rst(i_rst), .i_data(emit_beat), .i_enq(emit), .i_deq(o_out_write),
      .o_data(o_out_data), .o_empty(out_empty), .o_full(), .o_almost_full(out_almost_full));

endmodule

/* testbench/tb_merger.sv */
`timescale 1ns/1ps

module tb_merger import merger_pkg::*; ();

   localparam int LANES   = 4;
   localparam int TIMEOUT = 2000;   // cycles allowed per wait.

   typedef record_t [LANES-1:0] beat_t;

   logic        i_clk;
   logic        i_rst;
   beat_t       i_a_data;
   logic        i_a_empty;
   beat_t       i_b_data;
   logic        i_b_empty;
   logic        i_out_ready;
   logic        o_a_read;
   logic        o_b_read;
   logic        o_out_write;
   beat_t       o_out_data;

   beat_t       qa[$];          // upstream a, head first.
   beat_t       qb[$];
   beat_t       got[$];         // beats seen on the output.
   logic [31:0] exp_recs[$];    // expected records, sorted run by run.
   logic [31:0] run_recs[$];
   bit          ready_pat[$];   // per-cycle ready, then ready stays high.
   bit          pop_a;
   bit          pop_b;
   bit          starve_b;
   bit          last_ready;
   bit          timed_out;      // a wait gave up, later tests are skipped.
   logic [15:0] next_value;     // unique payload per record.
   string       cur_test;
   int          errors;
   int          tests_run;
   int          tests_failed;
   int          checks_failed;

   merger #(.LANES(LANES), .IN_DEPTH(8), .OUT_DEPTH(8)) merger_i (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_a_data(i_a_data), .i_a_empty(i_a_empty),
      .i_b_data(i_b_data), .i_b_empty(i_b_empty),
      .i_out_ready(i_out_ready),
      .o_a_read(o_a_read), .o_b_read(o_b_read),
      .o_out_write(o_out_write), .o_out_data(o_out_data));

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   //**********************************************************
   // upstream FIFO models and downstream ready
   //**********************************************************
   always @(negedge i_clk) begin
      pop_a = o_a_read;   // read strobes are stable here.
      pop_b = o_b_read;
   end

   always @(posedge i_clk) begin
      #1;
      if (pop_a && qa.size() > 0) begin
         qa.delete(0);
      end
      if (pop_b && qb.size() > 0) begin
         qb.delete(0);
      end
      i_a_empty   = (qa.size() == 0);
      i_a_data    = (qa.size() > 0) ? qa[0] : '0;
      i_b_empty   = (qb.size() == 0) || starve_b;
      i_b_data    = (qb.size() > 0) ? qb[0] : '0;
      i_out_ready = (ready_pat.size() > 0) ? ready_pat.pop_front() : 1'b1;
   end

   // output monitor, also checks the registered ready.
   always @(negedge i_clk) begin
      if (o_out_write === 1'b1) begin
         got.push_back(o_out_data);
         assert (last_ready) else begin
            $display("%s: o_out_write high one cycle after i_out_ready was low", cur_test);
            errors++;
         end
      end
      last_ready = i_out_ready;
   end

   //**********************************************************
   // reference model
   //**********************************************************
   task automatic add_stream(input int which, input int nbeats, input int keymax);
      logic [15:0] keys[$];
      beat_t       beat;
      for (int i = 0; i < nbeats * LANES; i++) begin
         keys.push_back(16'($urandom_range(keymax, 1)));   // zero is the terminator.
      end
      keys.sort();
      for (int b = 0; b < nbeats; b++) begin
         for (int l = 0; l < LANES; l++) begin
            beat[l].key   = keys[b * LANES + l];
            beat[l].value = next_value;
            next_value++;
            run_recs.push_back(beat[l]);
         end
         if (which == 0) qa.push_back(beat);
         else qb.push_back(beat);
      end
      if (which == 0) qa.push_back('0);
      else qb.push_back('0);
   endtask

   task automatic build_run(input int na, input int nb, input int keymax);
      run_recs.delete();
      add_stream(0, na, keymax);
      add_stream(1, nb, keymax);
      run_recs.sort();   // key order, ties broken by value.
      foreach (run_recs[i]) begin
         exp_recs.push_back(run_recs[i]);
      end
   endtask

   //**********************************************************
   // waits and checks
   //**********************************************************
   task automatic wait_beats(input int count);
      int waited;
      waited = 0;
      while (got.size() < count && waited < TIMEOUT) begin
         @(negedge i_clk);
         waited++;
      end
      if (got.size() < count) begin
         $display("%s: timed out with %0d of %0d output beats after %0d cycles",
                  cur_test, got.size(), count, waited);
         timed_out = 1'b1;
         errors++;
      end
   endtask

   task automatic wait_b_level(input int level);
      int waited;
      waited = 0;
      while (qb.size() > level && waited < TIMEOUT) begin
         @(negedge i_clk);
         waited++;
      end
      if (qb.size() > level) begin
         $display("%s: timed out waiting for stream b to be read down to %0d beats",
                  cur_test, level);
         timed_out = 1'b1;
         errors++;
      end
   endtask

   task automatic check_run(input string name, input int rec_first, input int nrec,
                            input int beat_first);
      logic [31:0] seen[$];
      int          nbeats;
      nbeats = nrec / LANES;
      for (int b = 0; b < nbeats; b++) begin
         for (int l = 0; l < LANES; l++) begin
            assert (got[beat_first + b][l].key == exp_recs[rec_first + b * LANES + l][31:16])
            else begin
               $display("error %s: beat %0d lane %0d expected key %h actual key %h", name, b, l,
                        exp_recs[rec_first + b * LANES + l][31:16], got[beat_first + b][l].key);
               errors++;
            end
            seen.push_back(got[beat_first + b][l]);
         end
      end
      assert (got[beat_first + nbeats] == '0) else begin
         $display("error %s: terminator expected %h actual %h", name, beat_t'(0),
                  got[beat_first + nbeats]);
         errors++;
      end
      // each record once, whatever the order among equal keys.
      seen.sort();
      for (int r = 0; r < nrec; r++) begin
         assert (seen[r] == exp_recs[rec_first + r]) else begin
            $display("error %s: record %0d expected %h actual %h", name, r,
                     exp_recs[rec_first + r], seen[r]);
            errors++;
         end
      end
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      errors   = 0;
      got.delete();
      exp_recs.delete();
   endtask

   task automatic finish_test(input int total);
      repeat (5) @(negedge i_clk);   // room for any stray beat.
      assert (got.size() == total) else begin
         $display("error %s: output beats expected %0d actual %0d", cur_test, total,
                  got.size());
         errors++;
      end
      tests_run++;
      checks_failed += errors;
      if (errors == 0) begin
         $display("%s: pass", cur_test);
      end else begin
         $display("%s: fail with %0d errors", cur_test, errors);
         tests_failed++;
      end
   endtask

   //**********************************************************
   // directed tests
   //**********************************************************
   task automatic run_single(input string name, input int na, input int nb, input int keymax);
      start_test(name);
      build_run(na, nb, keymax);
      wait_beats(na + nb + 1);
      if (!timed_out) begin
         check_run(name, 0, (na + nb) * LANES, 0);
      end
      finish_test(na + nb + 1);
   endtask

   task automatic test_back_pressure();
      start_test("back pressure");
      for (int i = 0; i < 150; i++) begin
         if (i >= 40 && i < 70) ready_pat.push_back(1'b0);   // long stall.
         else ready_pat.push_back(1'($urandom_range(1, 0)));
      end
      build_run(8, 8, 16'hffff);
      wait_beats(17);
      if (!timed_out) begin
         check_run("back pressure", 0, 16 * LANES, 0);
      end
      finish_test(17);
   endtask

   task automatic test_starved_input();
      start_test("starved input");
      build_run(10, 10, 16'hffff);
      wait_b_level(5);
      if (!timed_out) begin
         starve_b = 1'b1;
         repeat (20) @(negedge i_clk);
         starve_b = 1'b0;
         wait_beats(21);
      end
      if (!timed_out) begin
         check_run("starved input", 0, 20 * LANES, 0);
      end
      finish_test(21);
   endtask

   task automatic test_back_to_back();
      start_test("back to back");
      build_run(4, 5, 16'hffff);
      build_run(6, 3, 16'hffff);
      wait_beats(20);
      if (!timed_out) begin
         check_run("back to back run 1", 0, 9 * LANES, 0);
         check_run("back to back run 2", 9 * LANES, 9 * LANES, 10);
      end
      finish_test(20);
   endtask

   initial begin
      void'($urandom(32'h46d0_3940));
      i_rst         = 1'b1;
      i_a_data      = '0;
      i_a_empty     = 1'b1;
      i_b_data      = '0;
      i_b_empty     = 1'b1;
      i_out_ready   = 1'b1;
      next_value    = 16'h0001;
      timed_out     = 1'b0;
      tests_run     = 0;
      tests_failed  = 0;
      checks_failed = 0;
      cur_test      = "reset";
      repeat (3) @(posedge i_clk);
      #1;
      i_rst = 1'b0;
      @(negedge i_clk);

      run_single("basic merge", 6, 6, 16'hffff);
      if (!timed_out) run_single("empty stream", 0, 5, 16'hffff);
      if (!timed_out) run_single("equal keys", 7, 5, 6);   // narrow key range forces duplicates.
      if (!timed_out) test_back_pressure();
      if (!timed_out) test_starved_input();
      if (!timed_out) test_back_to_back();

      $display("tests run %0d, tests failed %0d, failed checks %0d",
               tests_run, tests_failed, checks_failed);
      if (tests_failed == 0 && !timed_out) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

/* merger.f */
verilog/merger_pkg.sv
verilog/sync_fifo.sv
verilog/bitonic_merge_network.sv
verilog/merge_control.sv
verilog/merger.sv
testbench/tb_merger.sv

/* Makefile */
TOP = tb_merger

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f merger.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
